//--- rtl/alarmBank.sv
// alarmBank module, twenty-four alarms and timers with match detection and firing stretch
`timescale 1ns/100ps

module alarmBank (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     almWrEnA,
  input  atsPkg::opcodeT                           almWrKindA,
  input  atsPkg::alarmIdT                          almWrIdA,
  input  atsPkg::clockIdT                          almWrClockA,
  input  logic                                     almWrRepeatA,
  input  logic                                     almWrEnableA,
  input  atsPkg::countT                            almWrValueA,
  input  logic                                     almWrEnB,
  input  atsPkg::opcodeT                           almWrKindB,
  input  atsPkg::alarmIdT                          almWrIdB,
  input  atsPkg::clockIdT                          almWrClockB,
  input  logic                                     almWrRepeatB,
  input  logic                                     almWrEnableB,
  input  atsPkg::countT                            almWrValueB,
  input  atsPkg::countT [atsPkg::numClocks-1:0]    counts,
  input  logic          [atsPkg::numClocks-1:0]    ticks,
  output atsPkg::alarmMaskT                        data
);

  logic            [atsPkg::numAlarms-1:0] enable, rptOn, match;
  // per-port write hits, one bit per alarm
  logic            [atsPkg::numAlarms-1:0] hitA, hitB;
  atsPkg::clockIdT                         clockSel [atsPkg::numAlarms];
  atsPkg::countT                           value    [atsPkg::numAlarms];
  // cycles of data left, 2 right after a match
  logic            [1:0]                   fireCnt  [atsPkg::numAlarms];
  atsPkg::countT                           timerValA, timerValB;

  // timer deadline from the assigned clock in the write cycle
  assign timerValA = almWrValueA + counts[almWrClockA];
  assign timerValB = almWrValueB + counts[almWrClockB];

  ////////////////////////////////////////////////////////////////////////////
  // match detection and data
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < atsPkg::numAlarms; i++) begin
      hitA[i]  = almWrEnA && almWrIdA == atsPkg::alarmIdT'(i);
      hitB[i]  = almWrEnB && almWrIdB == atsPkg::alarmIdT'(i);
      // compare against the count after this tick's increment
      match[i] = enable[i] && ticks[clockSel[i]] &&
                 (atsPkg::countT'(counts[clockSel[i]] + 1'b1) == value[i]);
      data[i]  = fireCnt[i] != 2'd0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // enables and firing counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      enable <= '0;
      for (int i = 0; i < atsPkg::numAlarms; i++) begin
        fireCnt[i] <= 2'd0;
      end
    end else begin
      for (int i = 0; i < atsPkg::numAlarms; i++) begin
        if (match[i]) begin
          fireCnt[i] <= 2'd2;
        end else if (fireCnt[i] != 2'd0) begin
          fireCnt[i] <= fireCnt[i] - 2'd1;
        end
        // one-shot alarms and timers switch off after firing
        if (match[i] && !rptOn[i]) begin
          enable[i] <= 1'b0;
        end
        // set alarm and set timer arm it, enable-only takes bit 23
        if (hitA[i]) begin
          enable[i] <= (almWrKindA == atsPkg::opAlarmEnable) ? almWrEnableA : 1'b1;
        end
        if (hitB[i]) begin
          enable[i] <= (almWrKindB == atsPkg::opAlarmEnable) ? almWrEnableB : 1'b1;
        end
      end
    end
  end

  // alarm settings, enable-only writes leave them alone
  always_ff @(posedge clk) begin
    for (int i = 0; i < atsPkg::numAlarms; i++) begin
      if (hitA[i] && almWrKindA != atsPkg::opAlarmEnable) begin
        clockSel[i] <= almWrClockA;
        value[i]    <= (almWrKindA == atsPkg::opSetTimer) ? timerValA : almWrValueA;
        rptOn[i]    <= (almWrKindA == atsPkg::opSetAlarm) && almWrRepeatA;
      end
      if (hitB[i] && almWrKindB != atsPkg::opAlarmEnable) begin
        clockSel[i] <= almWrClockB;
        value[i]    <= (almWrKindB == atsPkg::opSetTimer) ? timerValB : almWrValueB;
        rptOn[i]    <= (almWrKindB == atsPkg::opSetAlarm) && almWrRepeatB;
      end
    end
  end

  // a third high cycle in a row needs a fresh match in one of the two before
  for (genvar g = 0; g < atsPkg::numAlarms; g++) begin : gStretch
    assert property (@(posedge clk) disable iff (reset)
      (data[g] && $past(data[g]) && $past(data[g], 2)) |->
        ($past(match[g]) || $past(match[g], 2)));
  end

endmodule

//--- rtl/ats21.sv
// ats21 top level, capture, arbiter, clock bank and alarm bank
`timescale 1ns/100ps

module ats21 (
  input  logic              clk,
  input  logic              reset,
  input  logic              req,
  input  atsPkg::halfT      ctrlA,
  input  atsPkg::halfT      ctrlB,
  output logic              ready,
  output atsPkg::statT      stat,
  output atsPkg::alarmMaskT data
);

  // captured instructions, valid at E
  atsPkg::instrT   instrA, instrB;
  logic            validA, validB;

  // clock write ports, valid at E+1
  logic            clkWrEnA, clkWrSetA, clkWrEnableA;
  logic            clkWrEnB, clkWrSetB, clkWrEnableB;
  atsPkg::clockIdT clkWrIdA, clkWrIdB;
  atsPkg::rateT    clkWrRateA, clkWrRateB;
  atsPkg::countT   clkWrCountA, clkWrCountB;

  // alarm write ports, valid at E+1
  logic            almWrEnA, almWrRepeatA, almWrEnableA;
  logic            almWrEnB, almWrRepeatB, almWrEnableB;
  atsPkg::opcodeT  almWrKindA, almWrKindB;
  atsPkg::alarmIdT almWrIdA, almWrIdB;
  atsPkg::clockIdT almWrClockA, almWrClockB;
  atsPkg::countT   almWrValueA, almWrValueB;

  // clock state seen by the alarms
  atsPkg::countT [atsPkg::numClocks-1:0] counts;
  logic          [atsPkg::numClocks-1:0] ticks;

  ////////////////////////////////////////////////////////////////////////////
  // pipeline
  ////////////////////////////////////////////////////////////////////////////

  instrCapture captureA (
    .clk,
    .reset,
    .req,
    .ctrl       (ctrlA),
    .instr      (instrA),
    .instrValid (validA)
  );

  instrCapture captureB (
    .clk,
    .reset,
    .req,
    .ctrl       (ctrlB),
    .instr      (instrB),
    .instrValid (validB)
  );

  // remaining blocks share port and wire names
  cmdArbiter arbiter (.*);

  clockBank clocks (.*);

  alarmBank alarms (.*);

endmodule

//--- rtl/atsPkg.sv
// sizes, opcodes, instruction field types and capture state for the alarm/timer controller

package atsPkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  // software clocks and alarms
  localparam int numClocks = 16;
  localparam int numAlarms = 24;

  // counter width, also the alarm value width
  localparam int countWidth = 16;

  // one ctrl half, an instruction is two of them
  localparam int halfWidth = 16;

  ////////////////////////////////////////////////////////////////////////////
  // field types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [countWidth-1:0]        countT;
  typedef logic [halfWidth-1:0]         halfT;
  typedef logic [2*halfWidth-1:0]       instrT;
  // instruction bits 31:29
  typedef logic [2:0]                   opcodeT;
  typedef logic [$clog2(numClocks)-1:0] clockIdT;
  // instruction bits 28:24
  typedef logic [$clog2(numAlarms)-1:0] alarmIdT;
  // 00 every cycle, 01 every 2nd, 10 every 4th, 11 stopped
  typedef logic [1:0]                   rateT;
  // bit 0 client A, bit 1 client B, high means Ack
  typedef logic [1:0]                   statT;
  // one data bit per alarm
  typedef logic [numAlarms-1:0]         alarmMaskT;

  ////////////////////////////////////////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////////////////////////////////////////

  // client not taking part
  localparam opcodeT opNop         = 3'b000;
  localparam opcodeT opSetClock    = 3'b001;
  localparam opcodeT opClockEnable = 3'b010;
  // mode instruction, always refused
  localparam opcodeT opMode        = 3'b011;
  localparam opcodeT opSetAlarm    = 3'b101;
  localparam opcodeT opSetTimer    = 3'b110;
  // enable or disable an alarm or timer
  localparam opcodeT opAlarmEnable = 3'b111;

  // two-half capture FSM
  typedef enum logic {
    idle    = 1'b0,
    haveTop = 1'b1
  } captureStateT;

endpackage

//--- rtl/clockBank.sv
// clockBank module, sixteen software counters with rate prescaler and two write ports
`timescale 1ns/100ps

module clockBank (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     clkWrEnA,
  input  logic                                     clkWrSetA,
  input  atsPkg::clockIdT                          clkWrIdA,
  input  atsPkg::rateT                             clkWrRateA,
  input  logic                                     clkWrEnableA,
  input  atsPkg::countT                            clkWrCountA,
  input  logic                                     clkWrEnB,
  input  logic                                     clkWrSetB,
  input  atsPkg::clockIdT                          clkWrIdB,
  input  atsPkg::rateT                             clkWrRateB,
  input  logic                                     clkWrEnableB,
  input  atsPkg::countT                            clkWrCountB,
  output atsPkg::countT [atsPkg::numClocks-1:0]    counts,
  output logic          [atsPkg::numClocks-1:0]    ticks
);

  // free running phase shared by all clocks
  logic         [1:0]                   prescale;
  logic         [atsPkg::numClocks-1:0] enable;
  atsPkg::rateT                         rate [atsPkg::numClocks];

  ////////////////////////////////////////////////////////////////////////////
  // tick enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < atsPkg::numClocks; i++) begin
      case (rate[i])
        2'b00:   ticks[i] = enable[i];
        // odd phases
        2'b01:   ticks[i] = enable[i] && prescale[0];
        // phase 3 only
        2'b10:   ticks[i] = enable[i] && (&prescale);
        default: ticks[i] = 1'b0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // counters and writes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prescale <= '0;
      enable   <= '0;
      for (int i = 0; i < atsPkg::numClocks; i++) begin
        rate[i]   <= '0;
        counts[i] <= '0;
      end
    end else begin
      prescale <= prescale + 2'd1;
      for (int i = 0; i < atsPkg::numClocks; i++) begin
        if (ticks[i]) begin
          counts[i] <= counts[i] + atsPkg::countT'(1);
        end
        // a write wins over the tick in the same cycle
        if (clkWrEnA && clkWrIdA == atsPkg::clockIdT'(i)) begin
          if (clkWrSetA) begin
            counts[i] <= clkWrCountA;
            rate[i]   <= clkWrRateA;
          end
          enable[i] <= clkWrSetA || clkWrEnableA;
        end
        if (clkWrEnB && clkWrIdB == atsPkg::clockIdT'(i)) begin
          if (clkWrSetB) begin
            counts[i] <= clkWrCountB;
            rate[i]   <= clkWrRateB;
          end
          enable[i] <= clkWrSetB || clkWrEnableB;
        end
      end
    end
  end

  // the arbiter refuses same-clock pairs, so the ports never collide
  assert property (@(posedge clk) disable iff (reset)
    !(clkWrEnA && clkWrEnB && clkWrIdA == clkWrIdB));

endmodule

//--- rtl/cmdArbiter.sv
// cmdArbiter module, acceptance and conflict check with status and write commands
`timescale 1ns/100ps

module cmdArbiter (
  input  logic             clk,
  input  logic             reset,
  input  atsPkg::instrT    instrA,
  input  atsPkg::instrT    instrB,
  input  logic             validA,
  input  logic             validB,
  output logic             ready,
  output atsPkg::statT     stat,
  // clock write port A
  output logic             clkWrEnA,
  output logic             clkWrSetA,
  output atsPkg::clockIdT  clkWrIdA,
  output atsPkg::rateT     clkWrRateA,
  output logic             clkWrEnableA,
  output atsPkg::countT    clkWrCountA,
  // clock write port B
  output logic             clkWrEnB,
  output logic             clkWrSetB,
  output atsPkg::clockIdT  clkWrIdB,
  output atsPkg::rateT     clkWrRateB,
  output logic             clkWrEnableB,
  output atsPkg::countT    clkWrCountB,
  // alarm write port A, kind carries the opcode
  output logic             almWrEnA,
  output atsPkg::opcodeT   almWrKindA,
  output atsPkg::alarmIdT  almWrIdA,
  output atsPkg::clockIdT  almWrClockA,
  output logic             almWrRepeatA,
  output logic             almWrEnableA,
  output atsPkg::countT    almWrValueA,
  // alarm write port B
  output logic             almWrEnB,
  output atsPkg::opcodeT   almWrKindB,
  output atsPkg::alarmIdT  almWrIdB,
  output atsPkg::clockIdT  almWrClockB,
  output logic             almWrRepeatB,
  output logic             almWrEnableB,
  output atsPkg::countT    almWrValueB
);

  function automatic logic isClockOp(atsPkg::opcodeT op);
    return (op == atsPkg::opSetClock) || (op == atsPkg::opClockEnable);
  endfunction

  function automatic logic isAlarmOp(atsPkg::opcodeT op);
    return (op == atsPkg::opSetAlarm) || (op == atsPkg::opSetTimer) ||
           (op == atsPkg::opAlarmEnable);
  endfunction

  // single-client acceptance, before any conflict
  function automatic logic acceptable(atsPkg::instrT instr, logic valid);
    atsPkg::opcodeT op;
    op = instr[31:29];
    // mode is no longer supported
    if (!valid || op == atsPkg::opMode) begin
      return 1'b0;
    end
    if (isClockOp(op)) begin
      return 1'b1;
    end
    return isAlarmOp(op) && (instr[28:24] < atsPkg::alarmIdT'(atsPkg::numAlarms));
  endfunction

  atsPkg::opcodeT opA, opB;
  logic           conflict, okA, okB;

  assign opA = instrA[31:29];
  assign opB = instrB[31:29];

  // same clock or same alarm in one transfer refuses both clients
  assign conflict = validA && validB &&
                    ((isClockOp(opA) && isClockOp(opB) && instrA[28:25] == instrB[28:25]) ||
                     (isAlarmOp(opA) && isAlarmOp(opB) && instrA[28:24] == instrB[28:24]));
  assign okA      = acceptable(instrA, validA) && !conflict;
  assign okB      = acceptable(instrB, validB) && !conflict;

  ////////////////////////////////////////////////////////////////////////////
  // E+1 registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ready    <= 1'b0;
      stat     <= '0;
      clkWrEnA <= 1'b0;
      clkWrEnB <= 1'b0;
      almWrEnA <= 1'b0;
      almWrEnB <= 1'b0;
    end else begin
      ready    <= validA || validB;
      stat     <= {okB, okA};
      clkWrEnA <= okA && isClockOp(opA);
      clkWrEnB <= okB && isClockOp(opB);
      almWrEnA <= okA && isAlarmOp(opA);
      almWrEnB <= okB && isAlarmOp(opB);
    end
  end

  // field slices, only looked at while the matching enable is high
  always_ff @(posedge clk) begin
    clkWrSetA    <= opA == atsPkg::opSetClock;
    clkWrIdA     <= instrA[28:25];
    clkWrRateA   <= instrA[23:22];
    clkWrEnableA <= instrA[23];
    clkWrCountA  <= instrA[15:0];
    clkWrSetB    <= opB == atsPkg::opSetClock;
    clkWrIdB     <= instrB[28:25];
    clkWrRateB   <= instrB[23:22];
    clkWrEnableB <= instrB[23];
    clkWrCountB  <= instrB[15:0];
    almWrKindA   <= opA;
    almWrIdA     <= instrA[28:24];
    almWrClockA  <= instrA[19:16];
    almWrRepeatA <= instrA[23];
    almWrEnableA <= instrA[23];
    almWrValueA  <= instrA[15:0];
    almWrKindB   <= opB;
    almWrIdB     <= instrB[28:24];
    almWrClockB  <= instrB[19:16];
    almWrRepeatB <= instrB[23];
    almWrEnableB <= instrB[23];
    almWrValueB  <= instrB[15:0];
  end

  // writes only go out together with the status of their transfer
  assert property (@(posedge clk) disable iff (reset)
    (clkWrEnA || clkWrEnB || almWrEnA || almWrEnB) |-> ready);

endmodule

//--- rtl/instrCapture.sv
// instrCapture module, joins one client's two ctrl halves into one instruction
`timescale 1ns/100ps

module instrCapture (
  input  logic          clk,
  input  logic          reset,
  input  logic          req,
  input  atsPkg::halfT  ctrl,
  output atsPkg::instrT instr,
  output logic          instrValid
);

  atsPkg::captureStateT state;
  // upper half held until the lower one arrives
  atsPkg::halfT         top;
  atsPkg::opcodeT       ctrlOp;

  // opcode sits in the top bits of the first half
  assign ctrlOp = ctrl[atsPkg::halfWidth-1 -: $bits(atsPkg::opcodeT)];

  // control side of the FSM
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= atsPkg::idle;
      instrValid <= 1'b0;
    end else begin
      instrValid <= 1'b0;
      case (state)
        atsPkg::idle: begin
          // zero opcode means the client sits this pair out
          if (req && ctrlOp != atsPkg::opNop) begin
            state <= atsPkg::haveTop;
          end
        end
        default: begin
          // second half completes the word, or req dropped early
          instrValid <= req;
          state      <= atsPkg::idle;
        end
      endcase
    end
  end

  // instruction payload
  always_ff @(posedge clk) begin
    if (state == atsPkg::idle) begin
      top <= ctrl;
    end else if (req) begin
      instr <= {top, ctrl};
    end
  end

  // a pair takes two cycles, so the pulse can never repeat back to back
  assert property (@(posedge clk) disable iff (reset) instrValid |=> !instrValid);

endmodule

//--- sim.f
rtl/atsPkg.sv
rtl/instrCapture.sv
rtl/cmdArbiter.sv
rtl/clockBank.sv
rtl/alarmBank.sv
rtl/ats21.sv
sim/clockGen.sv
sim/ats21Tb.sv

//--- sim/ats21Tb.sv
// ats21Tb testbench top, stimulus, reference status function, compare tasks and watchdog
`timescale 1ns/100ps

module ats21Tb;

  logic              clk, reset, req, ready;
  atsPkg::halfT      ctrlA, ctrlB;
  atsPkg::statT      stat;
  atsPkg::alarmMaskT data;

  int seed = 14379;
  int cycleCount = 0;
  int errorCount = 0;
  // pending transfers, cycle of their ready and the status expected then
  int           dueQ[$];
  atsPkg::statT statQ[$];

  clockGen clocks (.clk, .reset);

  ats21 uut (.clk, .reset, .req, .ctrlA, .ctrlB, .ready, .stat, .data);

  always @(posedge clk) cycleCount <= cycleCount + 1;

  ////////////////////////////////////////////////////////////////////////////
  // reporting and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic failRun(string msg);
    errorCount++;
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkStat(string name, atsPkg::statT got, atsPkg::statT exp);
    if (got !== exp) begin
      failRun($sformatf("[ERROR] %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic checkData(string name, atsPkg::alarmMaskT got, atsPkg::alarmMaskT exp);
    if (got !== exp) begin
      failRun($sformatf("[ERROR] %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic checkReady(string name, logic got, logic exp);
    if (got !== exp) begin
      failRun($sformatf("[ERROR] %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // acceptance rules, bit 0 client A, bit 1 client B
  function automatic atsPkg::statT expectStat(atsPkg::instrT a, atsPkg::instrT b);
    atsPkg::opcodeT opA, opB;
    logic           clkA, clkB, almA, almB, okA, okB;
    opA  = a[31:29];
    opB  = b[31:29];
    clkA = (opA == atsPkg::opSetClock) || (opA == atsPkg::opClockEnable);
    clkB = (opB == atsPkg::opSetClock) || (opB == atsPkg::opClockEnable);
    almA = (opA == atsPkg::opSetAlarm) || (opA == atsPkg::opSetTimer) ||
           (opA == atsPkg::opAlarmEnable);
    almB = (opB == atsPkg::opSetAlarm) || (opB == atsPkg::opSetTimer) ||
           (opB == atsPkg::opAlarmEnable);
    // opcode 000 means no valid, so nop, mode and 100 all fall out here
    okA  = clkA || (almA && a[28:24] < 5'd24);
    okB  = clkB || (almB && b[28:24] < 5'd24);
    // same clock or same alarm in one transfer
    if ((clkA && clkB && a[28:25] == b[28:25]) || (almA && almB && a[28:24] == b[28:24])) begin
      return 2'b00;
    end
    return {okB, okA};
  endfunction

  // ready and stat checked each falling edge
  always @(negedge clk) begin
    if (dueQ.size() > 0 && dueQ[0] == cycleCount) begin
      checkReady("ready", ready, 1'b1);
      checkStat("stat", stat, statQ[0]);
      void'(dueQ.pop_front());
      void'(statQ.pop_front());
    end else begin
      checkReady("ready", ready, 1'b0);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic atsPkg::instrT clockInstr(atsPkg::opcodeT op, atsPkg::clockIdT id,
                                                atsPkg::rateT rate, atsPkg::countT count);
    // rate doubles as the enable flag in bit 23
    return {op, id, 1'b0, rate, 6'b0, count};
  endfunction

  function automatic atsPkg::instrT alarmInstr(atsPkg::opcodeT op, atsPkg::alarmIdT id,
                                                logic flag, atsPkg::clockIdT clockSel,
                                                atsPkg::countT value);
    return {op, id, flag, 3'b0, clockSel, value};
  endfunction

  // called on a falling edge, returns two falling edges later with req low
  task automatic sendPair(atsPkg::instrT a, atsPkg::instrT b);
    req   = 1'b1;
    ctrlA = a[31:16];
    ctrlB = b[31:16];
    @(negedge clk);
    ctrlA = a[15:0];
    ctrlB = b[15:0];
    // ready due two edges after the lower half is sampled
    if (a[31:29] != 3'b000 || b[31:29] != 3'b000) begin
      dueQ.push_back(cycleCount + 2);
      statQ.push_back(expectStat(a, b));
    end
    @(negedge clk);
    req   = 1'b0;
    ctrlA = '0;
    ctrlB = '0;
  endtask

  task automatic randomInstr(output atsPkg::instrT w);
    int sel;
    w   = $random(seed);
    sel = $random(seed) & 3;
    // tight index range, 25 stands for an alarm out of range
    w[28:24] = (sel == 3) ? 5'd25 : 5'(sel);
    // idle client drives zero on both halves
    if (($random(seed) & 3) == 0 || w[31:29] == atsPkg::opNop) begin
      w = '0;
    end
  endtask

  task automatic randomPairs(int count);
    atsPkg::instrT a, b;
    for (int i = 0; i < count; i++) begin
      randomInstr(a);
      randomInstr(b);
      sendPair(a, b);
    end
  endtask

  // switch off every alarm the random pairs may have armed
  task automatic clearAlarms();
    for (int i = 0; i < 12; i++) begin
      sendPair(alarmInstr(atsPkg::opAlarmEnable, 5'(i), 1'b0, 4'd0, 16'd0),
               alarmInstr(atsPkg::opAlarmEnable, 5'(i + 12), 1'b0, 4'd0, 16'd0));
    end
    // let firing stretches run out
    repeat (6) @(negedge clk);
    checkData("data", data, '0);
  endtask

  task automatic quietCycles(int count);
    repeat (count) begin
      @(negedge clk);
      checkData("data", data, '0);
    end
  endtask

  task automatic waitFire(int bitNum, int limit, output int riseAt);
    int waited;
    waited = 0;
    while (!data[bitNum]) begin
      if (waited == limit) begin
        failRun($sformatf("alarm %0d did not fire within %0d cycles", bitNum, limit));
      end
      checkData("data", data, '0);
      @(negedge clk);
      waited++;
    end
    riseAt = cycleCount;
    checkData("data", data, atsPkg::alarmMaskT'(1) << bitNum);
  endtask

  // rise, exactly two high cycles, then low
  task automatic fireOnce(int bitNum, int limit, output int riseAt);
    waitFire(bitNum, limit, riseAt);
    @(negedge clk);
    checkData("data", data, atsPkg::alarmMaskT'(1) << bitNum);
    @(negedge clk);
    checkData("data", data, '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic oneShotTest();
    int riseAt;
    sendPair(clockInstr(atsPkg::opSetClock, 4'd3, 2'b00, 16'd100), '0);
    sendPair(alarmInstr(atsPkg::opSetAlarm, 5'd5, 1'b0, 4'd3, 16'd140), '0);
    // ready edge
    @(negedge clk);
    fireOnce(5, 50, riseAt);
    // rewind clock 3 so an alarm still armed would reach 140 again
    sendPair(clockInstr(atsPkg::opSetClock, 4'd3, 2'b00, 16'd100), '0);
    quietCycles(300);
  endtask

  task automatic timerTest();
    int riseAt;
    sendPair(clockInstr(atsPkg::opSetClock, 4'd7, 2'b01, 16'd0), '0);
    sendPair(alarmInstr(atsPkg::opSetTimer, 5'd9, 1'b0, 4'd7, 16'd20), '0);
    @(negedge clk);
    // 20 ticks at half rate
    quietCycles(38);
    fireOnce(9, 10, riseAt);
  endtask

  task automatic disableTest();
    sendPair(clockInstr(atsPkg::opSetClock, 4'd2, 2'b00, 16'd0),
             clockInstr(atsPkg::opSetClock, 4'd4, 2'b00, 16'd0));
    sendPair(alarmInstr(atsPkg::opSetAlarm, 5'd11, 1'b0, 4'd2, 16'd60),
             alarmInstr(atsPkg::opSetAlarm, 5'd12, 1'b0, 4'd4, 16'd80));
    // alarm 11 off directly, alarm 12 loses its clock
    sendPair(alarmInstr(atsPkg::opAlarmEnable, 5'd11, 1'b0, 4'd0, 16'd0),
             clockInstr(atsPkg::opClockEnable, 4'd4, 2'b00, 16'd0));
    quietCycles(300);
  endtask

  task automatic repeatTest();
    int firstRise, secondRise, period;
    // one full wrap of the counter
    period = 1 << atsPkg::countWidth;
    sendPair(clockInstr(atsPkg::opSetClock, 4'd6, 2'b00, 16'd0), '0);
    sendPair(alarmInstr(atsPkg::opSetAlarm, 5'd20, 1'b1, 4'd6, 16'd50), '0);
    @(negedge clk);
    fireOnce(20, 100, firstRise);
    fireOnce(20, period, secondRise);
    if (secondRise - firstRise != period) begin
      failRun($sformatf("[ERROR] %0t repeat interval got %0d expected %0d",
                        $time, secondRise - firstRise, period));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    req   = 1'b0;
    ctrlA = '0;
    ctrlB = '0;
    @(negedge clk);
    while (reset) @(negedge clk);
    checkReady("ready", ready, 1'b0);
    checkStat("stat", stat, '0);
    checkData("data", data, '0);
    randomPairs(200);
    clearAlarms();
    oneShotTest();
    timerTest();
    disableTest();
    repeatTest();
    // last ready still to be compared
    repeat (4) @(negedge clk);
    if (dueQ.size() != 0) begin
      failRun("transfers still waiting for ready at the end of the run");
    end
    if (errorCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    int limit;
    // random pairs, directed tests, one counter wrap, then margin
    limit = 200 * 3 + 2000 + (1 << atsPkg::countWidth) + 4000;
    repeat (limit) @(posedge clk);
    failRun($sformatf("watchdog expired after %0d cycles", limit));
  end

endmodule

//--- sim/clockGen.sv
// clockGen module, testbench clock and reset source
`timescale 1ns/100ps

module clockGen (
  output logic clk,
  output logic reset
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held for the first four cycles, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;
  end

endmodule
